// File: rtl/tlbmiss_pkg.sv
`default_nettype none

package tlbmiss_pkg;

  localparam int VADDR_W    = 44;
  localparam int PAGE_SHIFT = 14;
  localparam int VPN_W      = 30;
  localparam int ATTR_W     = 4;
  localparam int SZ_W       = 5;
  localparam int LSQ_W      = 9;

  localparam int LANES = 2;
  localparam int DEPTH = 4;
  localparam int PTR_W = 2;

  // one load/store op on a lane
  typedef struct packed {
    logic              valid;
    logic              thread;
    logic [VADDR_W-1:0] vaddr;
    logic [SZ_W-1:0]    size;
    logic [ATTR_W-1:0]  attr;
    logic [LSQ_W-1:0]   lsq;
  } mop_t;

  // state of one stored lane
  typedef struct packed {
    logic stored;
    logic need_walk;
    logic invalid;
  } lane_flags_t;

  // page walk request with vpn as the vaddr bits above the page offset
  typedef struct packed {
    logic [VPN_W-1:0]  vpn;
    logic [ATTR_W-1:0] attr;
  } tlb_req_t;

endpackage

`default_nettype wire

// File: rtl/miss_ram.sv
`timescale 1ns/1ps
`default_nettype none

module miss_ram (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            rd_en_i,
  input  wire logic [tlbmiss_pkg::PTR_W-1:0]   rd_addr_i,
  output logic [$bits(tlbmiss_pkg::lane_flags_t)+$bits(tlbmiss_pkg::mop_t)-1:0] rd_data_o,
  input  wire logic                            wr_en_i,
  input  wire logic [tlbmiss_pkg::PTR_W-1:0]   wr_addr_i,
  input  wire logic [$bits(tlbmiss_pkg::lane_flags_t)+$bits(tlbmiss_pkg::mop_t)-1:0] wr_data_i
);
  import tlbmiss_pkg::*;

  logic [$bits(rd_data_o)-1:0] mem [DEPTH];
  logic [PTR_W-1:0]            rd_addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en_i) begin
      rd_addr_q <= rd_addr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // write-first since a same-cycle write shows up behind the address register
  assign rd_data_o = mem[rd_addr_q];

endmodule

`default_nettype wire

// File: rtl/miss_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module miss_buffer (
  input  wire logic                                            clk,
  input  wire logic                                            rst,
  input  wire tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]      op_i,
  input  wire logic [tlbmiss_pkg::LANES-1:0]                   miss_i,
  input  wire logic                                            stall_i,
  input  wire logic                                            except_i,
  input  wire logic                                            except_thread_i,
  input  wire logic                                            pop_i,
  output tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]           head_op_o,
  output tlbmiss_pkg::lane_flags_t [tlbmiss_pkg::LANES-1:0]    head_flags_o,
  output logic                                                 head_valid_o,
  output logic                                                 nonempty_o
);
  import tlbmiss_pkg::*;

  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_nxt;
  logic [PTR_W:0]           count_q;
  logic [LANES-1:0]         cap;
  logic                     full;
  logic                     push;
  logic [LANES-1:0]         thr_q [DEPTH];
  logic [LANES-1:0]         inv_q [DEPTH];
  lane_flags_t [LANES-1:0]  wr_flags;
  lane_flags_t [LANES-1:0]  rd_flags;
  logic [$bits(lane_flags_t)+$bits(mop_t)-1:0] rd_word [LANES];

  assign full       = count_q == (PTR_W+1)'(DEPTH);
  assign push       = |cap && !full;
  assign nonempty_o = count_q != '0;
  assign rd_ptr_nxt = rd_ptr_q + 1'b1;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      cap[l]                = op_i[l].valid && (miss_i[l] || stall_i);
      wr_flags[l].stored    = cap[l];
      wr_flags[l].need_walk = miss_i[l];
      wr_flags[l].invalid   = except_i && (except_thread_i == op_i[l].thread);
    end
  end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    miss_ram u_ram (
      .clk       (clk),
      .rst       (rst),
      .rd_en_i   (pop_i),
      .rd_addr_i (rd_ptr_nxt),
      .rd_data_o (rd_word[l]),
      .wr_en_i   (push),
      .wr_addr_i (wr_ptr_q),
      .wr_data_i ({wr_flags[l], op_i[l]})
    );
  end

  // capture-time invalid comes from the ram, later ones from inv_q
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      {rd_flags[l], head_op_o[l]} = rd_word[l];
      head_flags_o[l]             = rd_flags[l];
      head_flags_o[l].invalid     = rd_flags[l].invalid || inv_q[rd_ptr_q][l];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      head_valid_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_nxt;
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop_i);
      // next head is only good once the ram read has settled
      head_valid_o <= pop_i ? (count_q > (PTR_W+1)'(1)) : nonempty_o;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        thr_q[k] <= '0;
        inv_q[k] <= '0;
      end
    end else begin
      // one exception kills every lane of its thread at once
      if (except_i) begin
        for (int k = 0; k < DEPTH; k++) begin
          for (int l = 0; l < LANES; l++) begin
            if (thr_q[k][l] == except_thread_i) begin
              inv_q[k][l] <= 1'b1;
            end
          end
        end
      end
      if (push) begin
        for (int l = 0; l < LANES; l++) begin
          thr_q[wr_ptr_q][l] <= op_i[l].thread;
          inv_q[wr_ptr_q][l] <= 1'b0;
        end
      end
    end
  end

  // upstream holds off while every entry is taken
  a_no_cap_full: assert property (@(posedge clk) disable iff (rst) full |-> !(|cap));

  a_pop_head: assert property (@(posedge clk) disable iff (rst) pop_i |-> head_valid_o);

endmodule

`default_nettype wire

// File: rtl/replay_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module replay_ctrl (
  input  wire logic                                            clk,
  input  wire logic                                            rst,
  input  wire tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]      op_i,
  input  wire logic [tlbmiss_pkg::LANES-1:0]                   miss_i,
  input  wire logic                                            stall_i,
  input  wire logic                                            except_i,
  input  wire logic                                            except_thread_i,
  input  wire tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]      head_op_i,
  input  wire tlbmiss_pkg::lane_flags_t [tlbmiss_pkg::LANES-1:0] head_flags_i,
  input  wire logic                                            head_valid_i,
  input  wire logic                                            tlb_ack_i,
  output tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]           op_o,
  output logic                                                 tlb_req_valid_o,
  output tlbmiss_pkg::tlb_req_t                                tlb_req_o,
  output logic                                                 pop_o
);
  import tlbmiss_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WALK0,
    S_WALK1,
    S_REPLAY
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic             issued_q;
  logic             walking;
  logic             walk_lane;
  logic [LANES-1:0] kill;
  logic [LANES-1:0] need;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      kill[l] = except_i && (except_thread_i == head_op_i[l].thread);
      need[l] = head_flags_i[l].stored && head_flags_i[l].need_walk &&
                !head_flags_i[l].invalid && !kill[l];
    end
  end

  assign walking   = (state_q == S_WALK0) || (state_q == S_WALK1);
  assign walk_lane = state_q == S_WALK1;

  // once out, a request stays up until acked even if the lane dies
  assign tlb_req_valid_o = walking && (need[walk_lane] || issued_q);
  assign tlb_req_o.vpn   = head_op_i[walk_lane].vaddr[VADDR_W-1:PAGE_SHIFT];
  assign tlb_req_o.attr  = head_op_i[walk_lane].attr;
  assign pop_o           = state_q == S_REPLAY;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (head_valid_i) begin
          state_d = S_WALK0;
        end
      end
      S_WALK0: begin
        if (!tlb_req_valid_o || tlb_ack_i) begin
          state_d = S_WALK1;
        end
      end
      S_WALK1: begin
        if (!tlb_req_valid_o || tlb_ack_i) begin
          state_d = S_REPLAY;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= S_IDLE;
      issued_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      issued_q <= tlb_req_valid_o && !tlb_ack_i;
    end
  end

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      if (state_q == S_REPLAY) begin
        op_o[l]       = head_op_i[l];
        op_o[l].valid = head_flags_i[l].stored && !head_flags_i[l].invalid && !kill[l];
      end else begin
        op_o[l] = op_i[l];
        // captured lanes come back later from the buffer
        op_o[l].valid = op_i[l].valid && !(miss_i[l] || stall_i);
      end
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    tlb_req_valid_o && !tlb_ack_i |=> tlb_req_valid_o && $stable(tlb_req_o));

endmodule

`default_nettype wire

// File: rtl/tlb_miss_replay.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_miss_replay (
  input  wire logic                                        clk,
  input  wire logic                                        rst,
  input  wire tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]  op_i,
  input  wire logic [tlbmiss_pkg::LANES-1:0]               miss_i,
  input  wire logic                                        except_i,
  input  wire logic                                        except_thread_i,
  input  wire logic                                        tlb_ack_i,
  output tlbmiss_pkg::mop_t [tlbmiss_pkg::LANES-1:0]       op_o,
  output logic                                             stall_o,
  output logic                                             tlb_req_valid_o,
  output tlbmiss_pkg::tlb_req_t                            tlb_req_o
);
  import tlbmiss_pkg::*;

  mop_t [LANES-1:0]        head_op;
  lane_flags_t [LANES-1:0] head_flags;
  logic                    head_valid;
  logic                    pop;
  logic                    nonempty;

  miss_buffer u_buffer (
    .clk             (clk),
    .rst             (rst),
    .op_i            (op_i),
    .miss_i          (miss_i),
    .stall_i         (nonempty),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .pop_i           (pop),
    .head_op_o       (head_op),
    .head_flags_o    (head_flags),
    .head_valid_o    (head_valid),
    .nonempty_o      (nonempty)
  );

  replay_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .op_i            (op_i),
    .miss_i          (miss_i),
    .stall_i         (nonempty),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .head_op_i       (head_op),
    .head_flags_i    (head_flags),
    .head_valid_i    (head_valid),
    .tlb_ack_i       (tlb_ack_i),
    .op_o            (op_o),
    .tlb_req_valid_o (tlb_req_valid_o),
    .tlb_req_o       (tlb_req_o),
    .pop_o           (pop)
  );

  // pipeline stalls for as long as anything is buffered
  assign stall_o = nonempty;

endmodule

`default_nettype wire

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// one buffered pair of lanes as the model sees it
typedef struct packed {
  mop_t [LANES-1:0] op;
  logic [LANES-1:0] stored;
  logic [LANES-1:0] need;
  logic [LANES-1:0] inv;
  logic [LANES-1:0] walked;
} entry_t;

entry_t q[$];

function automatic mop_t pass_expect(mop_t op, logic miss, logic stall);
  mop_t r;
  r = op;
  r.valid = op.valid && !(miss || stall);
  return r;
endfunction

function automatic mop_t replay_expect(int lane, logic exc, logic thr);
  entry_t e;
  mop_t   r;
  e = q[0];
  r = e.op[lane];
  r.valid = e.stored[lane] && !e.inv[lane] && !(exc && (r.thread == thr));
  return r;
endfunction

function automatic tlb_req_t req_of(mop_t op);
  tlb_req_t r;
  r.vpn  = op.vaddr[VADDR_W-1:PAGE_SHIFT];
  r.attr = op.attr;
  return r;
endfunction

// everything but valid
function automatic logic same_fields(mop_t a, mop_t b);
  a.valid = 1'b0;
  b.valid = 1'b0;
  return a == b;
endfunction

// lane 0 goes before lane 1 and -1 means nothing is left
function automatic int next_walk_lane();
  entry_t e;
  if (q.size() == 0) begin
    return -1;
  end
  e = q[0];
  for (int l = 0; l < LANES; l++) begin
    if (e.stored[l] && e.need[l] && !e.inv[l] && !e.walked[l]) begin
      return l;
    end
  end
  return -1;
endfunction

function automatic void mark_walked(int lane);
  entry_t e;
  e = q[0];
  e.walked[lane] = 1'b1;
  q[0] = e;
endfunction

// one clock edge of the queue model
function automatic void model_step(mop_t [LANES-1:0] op, logic [LANES-1:0] miss,
                                   logic exc, logic thr, logic popped);
  entry_t           e;
  logic [LANES-1:0] cap;
  logic             full;
  full = q.size() >= DEPTH;
  for (int l = 0; l < LANES; l++) begin
    cap[l] = op[l].valid && (miss[l] || (q.size() != 0));
  end
  if (exc) begin
    for (int k = 0; k < q.size(); k++) begin
      e = q[k];
      for (int l = 0; l < LANES; l++) begin
        if (e.op[l].thread == thr) begin
          e.inv[l] = 1'b1;
        end
      end
      q[k] = e;
    end
  end
  if (|cap && !full) begin
    e.op     = op;
    e.stored = cap;
    e.need   = miss;
    e.walked = '0;
    for (int l = 0; l < LANES; l++) begin
      e.inv[l] = exc && (op[l].thread == thr);
    end
    q.push_back(e);
  end
  if (popped) begin
    void'(q.pop_front());
  end
endfunction

task automatic compare_mop(string what, mop_t got, mop_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic compare_req(tlb_req_t got, tlb_req_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %0t: walk request got %h expected %h", $time, got, exp);
  end
endtask

`endif

// File: sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import tlbmiss_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DLY       = 10;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic             clk;
  logic             rst;
  mop_t [LANES-1:0] op_i;
  logic [LANES-1:0] miss_i;
  logic             except_i;
  logic             except_thread_i;
  logic             tlb_ack_i;
  mop_t [LANES-1:0] op_o;
  logic             stall_o;
  logic             tlb_req_valid_o;
  tlb_req_t         tlb_req_o;

  integer     seed = 50;
  int         errors;
  int         checks;
  int         req_count;
  int         replay_count;
  int         err_mark;
  int         req_mark;
  int         replay_mark;
  logic [7:0] op_count;

  `include "tb_model.svh"

  tlb_miss_replay dut_i (
    .clk             (clk),
    .rst             (rst),
    .op_i            (op_i),
    .miss_i          (miss_i),
    .except_i        (except_i),
    .except_thread_i (except_thread_i),
    .tlb_ack_i       (tlb_ack_i),
    .op_o            (op_o),
    .stall_o         (stall_o),
    .tlb_req_valid_o (tlb_req_valid_o),
    .tlb_req_o       (tlb_req_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // low byte of vaddr is a running tag so every op is unique
  function automatic mop_t new_op(logic thr);
    mop_t op;
    op.valid      = 1'b1;
    op.thread     = thr;
    op.vaddr      = VADDR_W'({$random(seed), $random(seed)});
    op.vaddr[7:0] = op_count;
    op.size       = SZ_W'($random(seed));
    op.attr       = ATTR_W'($random(seed));
    op.lsq        = LSQ_W'(op_count);
    op_count      = op_count + 8'd1;
    return op;
  endfunction

  task automatic drive_cycle(mop_t op0, mop_t op1, logic [LANES-1:0] miss,
                             logic exc, logic thr);
    @(posedge clk);
    #DRIVE_DLY;
    op_i[0]         = op0;
    op_i[1]         = op1;
    miss_i          = miss;
    except_i        = exc;
    except_thread_i = thr;
  endtask

  task automatic drive_idle();
    drive_cycle('0, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic wait_drain();
    while (q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  task automatic finish_test(int num, string name, int req_exp, int replay_exp);
    if (req_count - req_mark != req_exp) begin
      errors++;
      $display("Fail %0t: %0d walk requests, expected %0d", $time, req_count - req_mark,
               req_exp);
    end
    if (replay_count - replay_mark != replay_exp) begin
      errors++;
      $display("Fail %0t: %0d replays, expected %0d", $time, replay_count - replay_mark,
               replay_exp);
    end
    if (errors == err_mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    end
    err_mark    = errors;
    req_mark    = req_count;
    replay_mark = replay_count;
  endtask

  initial begin
    rst             = 1'b1;
    op_i            = '0;
    miss_i          = '0;
    except_i        = 1'b0;
    except_thread_i = 1'b0;
    tlb_ack_i       = 1'b0;
    op_count        = 8'd1;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    for (int k = 0; k < 12; k++) begin
      drive_cycle(new_op(k[0]), new_op(!k[0]), 2'b00, 1'b0, 1'b0);
    end
    drive_idle();
    wait_drain();
    finish_test(1, "pass_through", 0, 0);

    drive_cycle(new_op(1'b0), new_op(1'b1), 2'b01, 1'b0, 1'b0);
    drive_idle();
    wait_drain();
    finish_test(2, "single_miss", 1, 1);

    drive_cycle(new_op(1'b1), new_op(1'b0), 2'b11, 1'b0, 1'b0);
    drive_idle();
    wait_drain();
    finish_test(3, "two_lane_miss", 2, 1);

    // later ops land in the buffer behind the first miss
    drive_cycle(new_op(1'b0), '0, 2'b01, 1'b0, 1'b0);
    drive_cycle(new_op(1'b0), new_op(1'b1), 2'b00, 1'b0, 1'b0);
    drive_cycle(new_op(1'b1), new_op(1'b0), 2'b10, 1'b0, 1'b0);
    drive_idle();
    wait_drain();
    finish_test(4, "capture_under_stall", 2, 3);

    drive_cycle(new_op(1'b0), new_op(1'b1), 2'b11, 1'b1, 1'b0);
    drive_idle();
    wait_drain();
    drive_cycle(new_op(1'b1), new_op(1'b1), 2'b11, 1'b0, 1'b0);
    drive_cycle(new_op(1'b0), new_op(1'b1), 2'b01, 1'b0, 1'b0);
    drive_cycle('0, '0, 2'b00, 1'b1, 1'b0);
    drive_idle();
    wait_drain();
    finish_test(5, "exception", 3, 3);

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // page walker stand-in that acks after 0 to 3 extra cycles
  initial begin : responder
    int wait_cycles;
    forever begin
      @(negedge clk);
      if (!rst && tlb_req_valid_o && !tlb_ack_i) begin
        wait_cycles = $unsigned($random(seed)) % 4;
        repeat (wait_cycles) @(posedge clk);
        @(posedge clk);
        #DRIVE_DLY;
        tlb_ack_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        tlb_ack_i = 1'b0;
      end
    end
  end

  initial begin : output_check
    int   wl;
    logic stall_exp;
    logic replay_seen;
    forever begin
      @(negedge clk);
      if (!rst) begin
        stall_exp = q.size() != 0;
        checks++;
        if (stall_o !== stall_exp) begin
          errors++;
          $display("Fail %0t: stall_o is %b, expected %b", $time, stall_o, stall_exp);
        end
        if (tlb_req_valid_o && tlb_ack_i) begin
          wl = next_walk_lane();
          if (wl < 0) begin
            errors++;
            $display("walk request at %0t was not expected by the model", $time);
          end else begin
            compare_req(tlb_req_o, req_of(q[0].op[wl]));
            mark_walked(wl);
            req_count++;
          end
        end
        replay_seen = stall_exp && same_fields(op_o[0], q[0].op[0]) &&
                      same_fields(op_o[1], q[0].op[1]);
        if (replay_seen) begin
          if (next_walk_lane() >= 0) begin
            errors++;
            $display("replay at %0t came before its walk requests were done", $time);
          end
          for (int l = 0; l < LANES; l++) begin
            compare_mop("replay op_o", op_o[l], replay_expect(l, except_i, except_thread_i));
          end
          replay_count++;
        end else begin
          for (int l = 0; l < LANES; l++) begin
            compare_mop("pass op_o", op_o[l], pass_expect(op_i[l], miss_i[l], stall_exp));
          end
        end
        model_step(op_i, miss_i, except_i, except_thread_i, replay_seen);
      end
    end
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog expired after %0d cycles without the tests finishing",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+sim
rtl/tlbmiss_pkg.sv
rtl/miss_ram.sv
rtl/miss_buffer.sv
rtl/replay_ctrl.sv
rtl/tlb_miss_replay.sv
sim/tb_top.sv

// File: Makefile
# Verilator build for the TLB-miss replay buffer

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Done: no errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
